// ==== core_defines.svh ====
// core-wide sizes and reset vector for the RV32I core
// widths are fixed by the ISA, do not change XLEN
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data and address width
`define XLEN 32

// integer register file
`define REG_COUNT 32
`define REG_IDX_W 5

// first fetch address after reset
`define RESET_PC 32'h8000_0000

`endif

// ==== isa_pkg.sv ====
// RV32I instruction encoding: opcodes and field layouts
// only the opcodes this core executes are enumerated
`include "core_defines.svh"

package isa_pkg;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011
    } opcode_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;   // raw bits, may hold unknown opcodes
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // same word seen as register fields, immediate fields or plain bits
    typedef union packed {
        r_fmt_t            r;
        i_fmt_t            i;
        logic [`XLEN-1:0]  raw;
    } inst_word_u;

endpackage

// ==== core_pkg.sv ====
// internal records of the core: ALU ops, decoded instruction, retire report
// no load/store or system kinds, anything unknown is kind_none
`include "core_defines.svh"

package core_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        kind_reg, kind_imm, kind_lui, kind_auipc,
        kind_jal, kind_jalr, kind_branch, kind_none
    } inst_kind_t;

    typedef struct packed {
        inst_kind_t            kind;
        alu_op_t               alu_op;
        logic [2:0]            funct3;   // branch condition for kind_branch
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`XLEN-1:0]      imm;      // already sign extended
    } decoded_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      next_pc;
        logic [`REG_IDX_W-1:0] rd;
        logic                  rd_we;
        logic [`XLEN-1:0]      rd_data;
    } retire_t;

endpackage

// ==== fetch_unit.sv ====
// two-cycle fetch/execute sequencer, memory answers in the fetch cycle
// run low only stalls before a fetch, never mid-instruction
`include "core_defines.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic [`XLEN-1:0]    next_pc,
    input  isa_pkg::inst_word_u imem_rdata,
    output logic [`XLEN-1:0]    pc,
    output isa_pkg::inst_word_u inst,
    output logic                imem_req,
    output logic                exec_valid
);

    typedef enum logic {
        st_fetch,
        st_exec
    } state_t;

    state_t state;

    assign imem_req   = (state == st_fetch) && run;
    assign exec_valid = (state == st_exec);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
            pc    <= `RESET_PC;
        end else begin
            if (imem_req)
                state <= st_exec;
            else if (exec_valid)
                state <= st_fetch;   // back to fetch, waits there while run is low
            if (exec_valid)
                pc <= next_pc;
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (imem_req)
            inst <= imem_rdata;
    end

endmodule

// ==== decode_unit.sv ====
// combinational RV32I decode for the integer, upper-immediate and control-flow formats
// unknown opcodes come out as kind_none with a zero immediate
`include "core_defines.svh"

module decode_unit (
    input  isa_pkg::inst_word_u inst,
    output core_pkg::decoded_t  dec
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_u;

    // immediates, all formats built in parallel
    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_b = {{20{inst.raw[31]}}, inst.raw[7], inst.raw[30:25], inst.raw[11:8], 1'b0};
    assign imm_j = {{12{inst.raw[31]}}, inst.raw[19:12], inst.raw[20], inst.raw[30:21], 1'b0};
    assign imm_u = {inst.raw[31:12], 12'b0};

    always_comb begin
        dec.funct3 = inst.r.funct3;
        dec.rd     = inst.r.rd;
        dec.rs1    = inst.r.rs1;
        dec.rs2    = inst.r.rs2;

        case (inst.r.opcode)
            isa_pkg::op_reg:    dec.kind = core_pkg::kind_reg;
            isa_pkg::op_imm:    dec.kind = core_pkg::kind_imm;
            isa_pkg::op_lui:    dec.kind = core_pkg::kind_lui;
            isa_pkg::op_auipc:  dec.kind = core_pkg::kind_auipc;
            isa_pkg::op_jal:    dec.kind = core_pkg::kind_jal;
            isa_pkg::op_jalr:   dec.kind = core_pkg::kind_jalr;
            isa_pkg::op_branch: dec.kind = core_pkg::kind_branch;
            default:            dec.kind = core_pkg::kind_none;
        endcase

        case (dec.kind)
            core_pkg::kind_imm, core_pkg::kind_jalr: dec.imm = imm_i;
            core_pkg::kind_branch:                   dec.imm = imm_b;
            core_pkg::kind_jal:                      dec.imm = imm_j;
            core_pkg::kind_lui, core_pkg::kind_auipc: dec.imm = imm_u;
            default:                                 dec.imm = '0;   // register form has none
        endcase

        dec.alu_op = core_pkg::alu_add;   // jumps and upper-imm just add
        if (dec.kind == core_pkg::kind_reg || dec.kind == core_pkg::kind_imm) begin
            case (inst.r.funct3)
                3'b000: begin
                    // sub only exists in the register form
                    if (dec.kind == core_pkg::kind_reg && inst.r.funct7[5])
                        dec.alu_op = core_pkg::alu_sub;
                end
                3'b001:  dec.alu_op = core_pkg::alu_sll;
                3'b010:  dec.alu_op = core_pkg::alu_slt;
                3'b011:  dec.alu_op = core_pkg::alu_sltu;
                3'b100:  dec.alu_op = core_pkg::alu_xor;
                3'b101:  dec.alu_op = inst.r.funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                3'b110:  dec.alu_op = core_pkg::alu_or;
                default: dec.alu_op = core_pkg::alu_and;
            endcase
        end
    end

endmodule

// ==== reg_file.sv ====
// 32 x 32 integer register file, two async reads and one sync write
// x0 is never written and always reads zero
`include "core_defines.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [`REG_IDX_W-1:0] waddr,
    input  logic [`REG_IDX_W-1:0] raddr1,
    input  logic [`REG_IDX_W-1:0] raddr2,
    input  logic [`XLEN-1:0]      wdata,
    output logic [`XLEN-1:0]      rdata1,
    output logic [`XLEN-1:0]      rdata2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin   // drop writes to x0
            regs[waddr] <= wdata;
        end
    end

    // x0 stays zero from reset on
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0));

endmodule

// ==== execute_unit.sv ====
// ALU, branch compare and next-pc selection, purely combinational
// kind_none behaves as a no-op: pc + 4 and no write
`include "core_defines.svh"

module execute_unit (
    input  core_pkg::decoded_t dec,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   rs1_val,
    input  logic [`XLEN-1:0]   rs2_val,
    output logic [`XLEN-1:0]   next_pc,
    output logic [`XLEN-1:0]   rd_data,
    output logic               rd_we
);

    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] seq_pc;
    logic [`XLEN-1:0] pc_target;
    logic             taken;

    assign seq_pc    = pc + 32'd4;
    assign pc_target = pc + dec.imm;   // branch and jal share it

    // operand select
    always_comb begin
        case (dec.kind)
            core_pkg::kind_imm, core_pkg::kind_jalr: begin
                alu_a = rs1_val;
                alu_b = dec.imm;
            end
            core_pkg::kind_lui: begin
                alu_a = '0;
                alu_b = dec.imm;
            end
            core_pkg::kind_auipc: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_val;
                alu_b = rs2_val;
            end
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            core_pkg::alu_sub:  alu_result = alu_a - alu_b;
            core_pkg::alu_sll:  alu_result = alu_a << alu_b[4:0];
            core_pkg::alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            core_pkg::alu_sltu: alu_result = {31'b0, alu_a < alu_b};
            core_pkg::alu_xor:  alu_result = alu_a ^ alu_b;
            core_pkg::alu_srl:  alu_result = alu_a >> alu_b[4:0];
            core_pkg::alu_sra:  alu_result = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            core_pkg::alu_or:   alu_result = alu_a | alu_b;
            core_pkg::alu_and:  alu_result = alu_a & alu_b;
            default:            alu_result = alu_a + alu_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_val == rs2_val);
            3'b001:  taken = (rs1_val != rs2_val);
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  taken = (rs1_val < rs2_val);
            3'b111:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;   // reserved encodings fall through
        endcase
    end

    always_comb begin
        case (dec.kind)
            core_pkg::kind_jal:    next_pc = pc_target;
            core_pkg::kind_jalr:   next_pc = {alu_result[`XLEN-1:1], 1'b0};
            core_pkg::kind_branch: next_pc = taken ? pc_target : seq_pc;
            default:               next_pc = seq_pc;
        endcase
    end

    assign rd_data = (dec.kind == core_pkg::kind_jal || dec.kind == core_pkg::kind_jalr)
                   ? seq_pc : alu_result;   // link address for jumps
    assign rd_we   = (dec.kind != core_pkg::kind_branch) && (dec.kind != core_pkg::kind_none);

endmodule

// ==== retire_unit.sv ====
// registered retire report, one pulse per executed instruction
module retire_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              exec_valid,
    input  core_pkg::retire_t rec_in,
    output logic              retire_valid,
    output core_pkg::retire_t retire
);

    always_ff @(posedge clk) begin
        if (reset)
            retire_valid <= 1'b0;
        else
            retire_valid <= exec_valid;   // one cycle after execute
    end

    always_ff @(posedge clk) begin
        if (exec_valid)
            retire <= rec_in;   // held until the next instruction retires
    end

    // execute never lasts two cycles, so neither does the report
    a_single_pulse: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid);

endmodule

// ==== rv_core.sv ====
// RV32I core without loads, stores or CSRs, two cycles per instruction
// imem_rdata must be valid in the same cycle as imem_req
`include "core_defines.svh"

module rv_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  logic [`XLEN-1:0]  imem_rdata,
    output logic [`XLEN-1:0]  imem_addr,
    output logic              imem_req,
    output logic              retire_valid,
    output core_pkg::retire_t retire
);

    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    next_pc;
    logic [`XLEN-1:0]    rs1_val;
    logic [`XLEN-1:0]    rs2_val;
    logic [`XLEN-1:0]    rd_data;
    logic                rd_we;
    logic                exec_valid;
    isa_pkg::inst_word_u inst;
    core_pkg::decoded_t  dec;
    core_pkg::retire_t   rec;

    assign imem_addr = pc;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .next_pc    (next_pc),
        .imem_rdata (imem_rdata),
        .pc         (pc),
        .inst       (inst),
        .imem_req   (imem_req),
        .exec_valid (exec_valid)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (exec_valid && rd_we),   // only at the end of execute
        .waddr  (dec.rd),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .wdata  (rd_data),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    execute_unit u_exec (
        .dec     (dec),
        .pc      (pc),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .next_pc (next_pc),
        .rd_data (rd_data),
        .rd_we   (rd_we)
    );

    assign rec.pc      = pc;
    assign rec.next_pc = next_pc;
    assign rec.rd      = dec.rd;
    assign rec.rd_we   = rd_we;
    assign rec.rd_data = rd_data;

    retire_unit u_retire (
        .clk          (clk),
        .reset        (reset),
        .exec_valid   (exec_valid),
        .rec_in       (rec),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// ==== tb_rv_core.sv ====
// random RV32I program with a few fixed instructions, checked against an ISA model per retire
// program is 256 words, addresses wrap through pc bits 9:2
`include "core_defines.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              reset;
    logic              run;
    logic [`XLEN-1:0]  imem_rdata;
    logic [`XLEN-1:0]  imem_addr;
    logic              imem_req;
    logic              retire_valid;
    core_pkg::retire_t retire;

    logic [31:0] prog [256];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    integer      seed;
    int          retire_count;
    int          checks;
    int          value_errors;
    int          protocol_errors;
    bit          timed_out;
    logic        prev_rv;

    assign imem_rdata = prog[imem_addr[9:2]];   // same-cycle answer, no handshake

    rv_core DUT (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .imem_rdata   (imem_rdata),
        .imem_addr    (imem_addr),
        .imem_req     (imem_req),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // legal encodings only, branches and jal jump forward
    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [2:0]  f3;
        int          kind;
        r = $random(seed);
        kind = $unsigned($random(seed)) % 8;
        f3 = r[17:15];
        case (kind)
            0, 1: begin
                if (f3 == 3'd0 || f3 == 3'd5)
                    return r_type({1'b0, r[18], 5'b0}, r[14:10], r[9:5], f3, r[4:0]);
                return r_type(7'b0, r[14:10], r[9:5], f3, r[4:0]);
            end
            2, 3: begin
                if (f3 == 3'd1)
                    return i_type({7'b0, r[14:10]}, r[9:5], f3, r[4:0], 7'h13);
                if (f3 == 3'd5)
                    return i_type({1'b0, r[18], 5'b0, r[14:10]}, r[9:5], f3, r[4:0], 7'h13);
                return i_type(r[29:18], r[9:5], f3, r[4:0], 7'h13);
            end
            4: return u_type(r[31:12], r[4:0], r[18] ? 7'h37 : 7'h17);
            5: begin
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = f3 + 3'd4;   // skip reserved conditions
                return branch_word({5'b0, {1'b0, r[22:18]} + 6'd1, 2'b0}, r[14:10], r[9:5], f3);
            end
            6: return jal_word({13'b0, {1'b0, r[22:18]} + 6'd1, 2'b0}, r[4:0]);
            default: return i_type(r[29:18], r[9:5], 3'd0, r[4:0], 7'h67);
        endcase
    endfunction

    task automatic fill_program();
        for (int i = 0; i < 256; i++)
            prog[i] = random_inst();
        prog[0]  = i_type(12'hffb, 5'd0, 3'd0, 5'd1, 7'h13);   // addi x1, x0, -5
        prog[1]  = i_type(12'd7, 5'd0, 3'd0, 5'd0, 7'h13);     // write to x0
        prog[2]  = r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd2);      // add x2, x0, x0
        prog[3]  = r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd3);      // sub
        prog[4]  = i_type(12'h401, 5'd1, 3'd5, 5'd4, 7'h13);   // srai by 1
        prog[5]  = r_type(7'h00, 5'd3, 5'd1, 3'd2, 5'd5);      // slt
        prog[6]  = r_type(7'h00, 5'd3, 5'd1, 3'd3, 5'd6);      // sltu
        prog[7]  = u_type(20'habcde, 5'd7, 7'h37);             // lui
        prog[8]  = u_type(20'h00001, 5'd8, 7'h17);             // auipc
        prog[9]  = jal_word(21'd8, 5'd9);                      // skips word 10
        prog[11] = i_type(12'd9, 5'd9, 3'd0, 5'd10, 7'h67);    // jalr, odd sum lands on word 12
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA model, one instruction per call, updates ref_regs and ref_pc
    function automatic core_pkg::retire_t ref_step();
        logic [31:0]       w;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       imm_i;
        logic [31:0]       imm_b;
        logic [31:0]       imm_j;
        logic [31:0]       next;
        logic [2:0]        f3;
        logic              take;
        core_pkg::retire_t rec;
        w = prog[ref_pc[9:2]];
        f3 = w[14:12];
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        take = 1'b0;
        next = ref_pc + 32'd4;
        rec.pc = ref_pc;
        rec.rd = w[11:7];
        rec.rd_we = 1'b1;
        rec.rd_data = 32'd0;
        case (w[6:0])
            7'h33: rec.rd_data = alu_ref(f3, w[30], a, b);
            7'h13: rec.rd_data = alu_ref(f3, (f3 == 3'd5) && w[30], a, imm_i);
            7'h37: rec.rd_data = {w[31:12], 12'b0};
            7'h17: rec.rd_data = ref_pc + {w[31:12], 12'b0};
            7'h6f: begin
                rec.rd_data = ref_pc + 32'd4;
                next = ref_pc + imm_j;
            end
            7'h67: begin
                rec.rd_data = ref_pc + 32'd4;
                next = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    default: take = (a >= b);
                endcase
                rec.rd_we = 1'b0;
                if (take)
                    next = ref_pc + imm_b;
            end
            default: rec.rd_we = 1'b0;   // unknown opcode is a no-op
        endcase
        rec.next_pc = next;
        if (rec.rd_we && rec.rd != 5'd0)
            ref_regs[rec.rd] = rec.rd_data;
        ref_pc = next;
        return rec;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_retires(input int target);
        int cycles;
        int limit;
        cycles = 0;
        limit = 4 * (target - retire_count) + 50;
        while (retire_count < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (retire_count < target) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d instructions retired after %0d cycles",
                     retire_count, target, cycles);
        end
    endtask

    // compare each retire with the model
    always @(negedge clk) begin
        core_pkg::retire_t expected;
        if (reset) begin
            prev_rv = 1'b0;
        end else begin
            if (retire_valid) begin
                if (prev_rv) begin
                    protocol_errors++;
                    $display("retire_valid stayed high for two cycles in a row");
                end
                expected = ref_step();
                if (retire_count == 0)
                    check("first retire pc", `RESET_PC, retire.pc);
                check("pc", expected.pc, retire.pc);
                check("next_pc", expected.next_pc, retire.next_pc);
                check("rd_we", {31'b0, expected.rd_we}, {31'b0, retire.rd_we});
                if (expected.rd_we) begin
                    check("rd", {27'b0, expected.rd}, {27'b0, retire.rd});
                    check("rd_data", expected.rd_data, retire.rd_data);
                end
                retire_count++;
            end
            prev_rv = retire_valid;
        end
    end

    initial begin
        int stall_len;
        int pulses;
        seed = 32'hb9c095b9;
        reset = 1'b1;
        run = 1'b0;
        retire_count = 0;
        checks = 0;
        value_errors = 0;
        protocol_errors = 0;
        timed_out = 1'b0;
        prev_rv = 1'b0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = 32'd0;
        ref_pc = `RESET_PC;
        fill_program();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check("idle imem_req", 32'd0, {31'b0, imem_req});
        check("idle retire_valid", 32'd0, {31'b0, retire_valid});
        run = 1'b1;
        #5;
        check("first fetch req", 32'd1, {31'b0, imem_req});
        check("first fetch addr", `RESET_PC, imem_addr);
        for (int round = 0; round < 12 && !timed_out; round++) begin
            wait_retires(retire_count + 30 + $unsigned($random(seed)) % 20);
            @(negedge clk);
            run = 1'b0;
            stall_len = 2 + $unsigned($random(seed)) % 10;
            pulses = 0;
            repeat (stall_len) begin
                @(negedge clk);
                if (retire_valid)
                    pulses++;   // only the instruction already fetched
                check("stalled imem_req", 32'd0, {31'b0, imem_req});
            end
            if (pulses != 1) begin
                protocol_errors++;
                $display("retire_valid pulsed %0d times while run was low, expected once",
                         pulses);
            end
            run = 1'b1;
        end
        if (!timed_out)
            wait_retires(retire_count + 50);
        $display("retired %0d, checks %0d, value errors %0d, protocol errors %0d, timeout %0d",
                 retire_count, checks, value_errors, protocol_errors, timed_out);
        if (value_errors == 0 && protocol_errors == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
retire_unit.sv
rv_core.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator, result decided from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary -f src.f --top-module tb_rv_core -Mdir obj_dir
./obj_dir/Vtb_rv_core > sim.log
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    echo "run.sh: test passed"
else
    echo "run.sh: test failed, see sim.log"
    exit 1
fi
